// File: hdl/processorci_pkg.sv
`default_nettype none

package processorci_pkg;

  // Data, instruction and address widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // Operations the core understands, anything else decodes to OP_NOP
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_LW,
    OP_SW,
    OP_BEQ,
    OP_BNE,
    OP_JAL,
    OP_NOP
  } op_e;

  // Multicycle sequencer phases
  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXEC,
    ST_MEM,
    ST_WB
  } seq_state_e;

  typedef struct packed {
    op_e      op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
  } decoded_t;

  // For JAL the link value travels in alu
  typedef struct packed {
    word_t alu;
    logic  taken;
    addr_t next_pc;
    addr_t mem_addr;
    word_t store_data;
  } exec_result_t;

endpackage

`default_nettype wire

// File: hdl/core_bus_seq.sv
`timescale 1ns/1ps
`default_nettype none

module core_bus_seq #(
  parameter processorci_pkg::addr_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic                          sys_clk_i,
  input  logic                          rst_n_i,

  output logic                          core_cyc_o,
  output logic                          core_stb_o,
  output logic                          core_we_o,
  output processorci_pkg::addr_t        core_addr_o,
  output processorci_pkg::word_t        core_data_o,
  input  processorci_pkg::word_t        core_data_i,
  input  logic                          core_ack_i,

  input  processorci_pkg::exec_result_t exec_i,
  input  processorci_pkg::op_e          op_i,
  output processorci_pkg::word_t        instr_o,
  output processorci_pkg::addr_t        pc_o,
  output processorci_pkg::word_t        load_data_o,
  output logic                          decode_en_o,
  output logic                          exec_en_o,
  output logic                          wb_en_o
);

  processorci_pkg::seq_state_e state_q;
  processorci_pkg::addr_t      pc_q;
  processorci_pkg::word_t      instr_q;
  processorci_pkg::word_t      load_q;
  logic                        cyc_q;
  logic                        mem_op;

  assign mem_op = (op_i == processorci_pkg::OP_LW) || (op_i == processorci_pkg::OP_SW);

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= processorci_pkg::ST_FETCH;
      pc_q    <= BOOT_ADDR;
      cyc_q   <= 1'b0;
    end else begin
      case (state_q)
        processorci_pkg::ST_FETCH: begin
          // First cycle after reset only raises the request
          if (cyc_q && core_ack_i) begin
            cyc_q   <= 1'b0;
            state_q <= processorci_pkg::ST_DECODE;
          end else begin
            cyc_q <= 1'b1;
          end
        end
        processorci_pkg::ST_DECODE: state_q <= processorci_pkg::ST_EXEC;
        processorci_pkg::ST_EXEC: begin
          if (mem_op) begin
            cyc_q   <= 1'b1;
            state_q <= processorci_pkg::ST_MEM;
          end else begin
            state_q <= processorci_pkg::ST_WB;
          end
        end
        processorci_pkg::ST_MEM: begin
          if (core_ack_i) begin
            cyc_q   <= 1'b0;
            state_q <= processorci_pkg::ST_WB;
          end
        end
        processorci_pkg::ST_WB: begin
          // Next fetch request goes out on the following cycle
          pc_q    <= exec_i.next_pc;
          cyc_q   <= 1'b1;
          state_q <= processorci_pkg::ST_FETCH;
        end
        default: state_q <= processorci_pkg::ST_FETCH;
      endcase
    end
  end

  // Instruction and load word capture on ack
  always_ff @(posedge sys_clk_i) begin
    if (state_q == processorci_pkg::ST_FETCH && cyc_q && core_ack_i) begin
      instr_q <= core_data_i;
    end
    if (state_q == processorci_pkg::ST_MEM && core_ack_i) begin
      load_q <= core_data_i;
    end
  end

  // Bus outputs come from registers only, stable until ack
  assign core_cyc_o  = cyc_q;
  assign core_stb_o  = cyc_q;
  assign core_we_o   = cyc_q && (state_q == processorci_pkg::ST_MEM) &&
                       (op_i == processorci_pkg::OP_SW);
  assign core_addr_o = (state_q == processorci_pkg::ST_MEM) ? exec_i.mem_addr : pc_q;
  assign core_data_o = exec_i.store_data;

  assign instr_o     = instr_q;
  assign pc_o        = pc_q;
  assign load_data_o = load_q;
  assign decode_en_o = (state_q == processorci_pkg::ST_DECODE);
  assign exec_en_o   = (state_q == processorci_pkg::ST_EXEC);
  assign wb_en_o     = (state_q == processorci_pkg::ST_WB);

endmodule

`default_nettype wire

// File: hdl/core_decode.sv
`timescale 1ns/1ps
`default_nettype none

module core_decode (
  input  logic                      sys_clk_i,
  input  logic                      rst_n_i,
  input  logic                      en_i,
  input  processorci_pkg::word_t    instr_i,
  output processorci_pkg::decoded_t dec_o
);

  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  processorci_pkg::decoded_t dec_d;
  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    dec_d.op  = processorci_pkg::OP_NOP;
    dec_d.rd  = instr_i[11:7];
    dec_d.rs1 = instr_i[19:15];
    dec_d.rs2 = instr_i[24:20];
    // I-type immediate unless the format says otherwise
    dec_d.imm = {{20{instr_i[31]}}, instr_i[31:20]};
    case (opcode)
      OPC_REG: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  dec_d.op = processorci_pkg::OP_ADD;
            3'b111:  dec_d.op = processorci_pkg::OP_AND;
            3'b110:  dec_d.op = processorci_pkg::OP_OR;
            3'b100:  dec_d.op = processorci_pkg::OP_XOR;
            default: dec_d.op = processorci_pkg::OP_NOP;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec_d.op = processorci_pkg::OP_SUB;
        end
      end
      OPC_IMM: if (funct3 == 3'b000) dec_d.op = processorci_pkg::OP_ADDI;
      OPC_LUI: begin
        dec_d.op  = processorci_pkg::OP_LUI;
        dec_d.imm = {instr_i[31:12], 12'b0};
      end
      OPC_LOAD: if (funct3 == 3'b010) dec_d.op = processorci_pkg::OP_LW;
      OPC_STORE: begin
        if (funct3 == 3'b010) dec_d.op = processorci_pkg::OP_SW;
        dec_d.imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b000) dec_d.op = processorci_pkg::OP_BEQ;
        if (funct3 == 3'b001) dec_d.op = processorci_pkg::OP_BNE;
        dec_d.imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                     instr_i[30:25], instr_i[11:8], 1'b0};
      end
      OPC_JAL: begin
        dec_d.op  = processorci_pkg::OP_JAL;
        dec_d.imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                     instr_i[20], instr_i[30:21], 1'b0};
      end
      default: dec_d.op = processorci_pkg::OP_NOP;
    endcase
  end

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_o <= '{op: processorci_pkg::OP_NOP, default: '0};
    end else if (en_i) begin
      dec_o <= dec_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/core_execute.sv
`timescale 1ns/1ps
`default_nettype none

module core_execute (
  input  logic                          sys_clk_i,
  input  logic                          rst_n_i,
  input  logic                          en_i,
  input  processorci_pkg::decoded_t     dec_i,
  input  processorci_pkg::addr_t        pc_i,
  input  processorci_pkg::word_t        rs1_val_i,
  input  processorci_pkg::word_t        rs2_val_i,
  output processorci_pkg::exec_result_t exec_o
);

  processorci_pkg::exec_result_t exec_d;
  processorci_pkg::addr_t        pc_plus4;

  assign pc_plus4 = pc_i + 32'd4;

  always_comb begin
    exec_d.mem_addr   = rs1_val_i + dec_i.imm;
    exec_d.store_data = rs2_val_i;
    exec_d.taken      = 1'b0;

    case (dec_i.op)
      processorci_pkg::OP_ADD:  exec_d.alu = rs1_val_i + rs2_val_i;
      processorci_pkg::OP_SUB:  exec_d.alu = rs1_val_i - rs2_val_i;
      processorci_pkg::OP_AND:  exec_d.alu = rs1_val_i & rs2_val_i;
      processorci_pkg::OP_OR:   exec_d.alu = rs1_val_i | rs2_val_i;
      processorci_pkg::OP_XOR:  exec_d.alu = rs1_val_i ^ rs2_val_i;
      processorci_pkg::OP_ADDI: exec_d.alu = rs1_val_i + dec_i.imm;
      processorci_pkg::OP_LUI:  exec_d.alu = dec_i.imm;
      // Link value for the return address
      processorci_pkg::OP_JAL:  exec_d.alu = pc_plus4;
      default:                  exec_d.alu = '0;
    endcase

    case (dec_i.op)
      processorci_pkg::OP_BEQ: exec_d.taken = (rs1_val_i == rs2_val_i);
      processorci_pkg::OP_BNE: exec_d.taken = (rs1_val_i != rs2_val_i);
      processorci_pkg::OP_JAL: exec_d.taken = 1'b1;
      default:                 exec_d.taken = 1'b0;
    endcase

    // Branch and JAL targets are both PC relative
    exec_d.next_pc = exec_d.taken ? (pc_i + dec_i.imm) : pc_plus4;
  end

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exec_o <= '0;
    end else if (en_i) begin
      exec_o <= exec_d;
    end
  end

endmodule

`default_nettype wire

// File: hdl/core_result.sv
`timescale 1ns/1ps
`default_nettype none

module core_result (
  input  logic                          sys_clk_i,
  input  logic                          rst_n_i,
  input  logic                          wb_en_i,
  input  processorci_pkg::decoded_t     dec_i,
  input  processorci_pkg::exec_result_t exec_i,
  input  processorci_pkg::word_t        load_data_i,
  output processorci_pkg::word_t        rs1_val_o,
  output processorci_pkg::word_t        rs2_val_o
);

  processorci_pkg::word_t regs [32];
  processorci_pkg::word_t wb_val;
  logic                   wb_we;

  // Writeback source per operation
  always_comb begin
    wb_val = exec_i.alu;
    wb_we  = 1'b0;
    case (dec_i.op)
      processorci_pkg::OP_ADD, processorci_pkg::OP_SUB, processorci_pkg::OP_AND,
      processorci_pkg::OP_OR, processorci_pkg::OP_XOR, processorci_pkg::OP_ADDI,
      processorci_pkg::OP_LUI, processorci_pkg::OP_JAL: wb_we = 1'b1;
      processorci_pkg::OP_LW: begin
        wb_val = load_data_i;
        wb_we  = 1'b1;
      end
      default: wb_we = 1'b0;
    endcase
  end

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && wb_we && dec_i.rd != 5'd0) begin
      regs[dec_i.rd] <= wb_val;
    end
  end

  // x0 is never written, so it reads back as zero
  assign rs1_val_o = regs[dec_i.rs1];
  assign rs2_val_o = regs[dec_i.rs2];

endmodule

`default_nettype wire

// File: hdl/processorci_top.sv
`timescale 1ns/1ps
`default_nettype none

module processorci_top #(
  parameter processorci_pkg::addr_t BOOT_ADDR = 32'h0000_0000
) (
  input  logic                   sys_clk_i,
  input  logic                   rst_n_i,

  // Wishbone master toward the memory
  output logic                   core_cyc_o,
  output logic                   core_stb_o,
  output logic                   core_we_o,
  output processorci_pkg::addr_t core_addr_o,
  output processorci_pkg::word_t core_data_o,
  input  processorci_pkg::word_t core_data_i,
  input  logic                   core_ack_i
);

  processorci_pkg::word_t        instr;
  processorci_pkg::addr_t        pc;
  processorci_pkg::word_t        load_data;
  processorci_pkg::decoded_t     dec;
  processorci_pkg::exec_result_t exec;
  processorci_pkg::word_t        rs1_val;
  processorci_pkg::word_t        rs2_val;
  logic                          decode_en;
  logic                          exec_en;
  logic                          wb_en;

  core_bus_seq #(
    .BOOT_ADDR   (BOOT_ADDR)
  ) u_core_bus_seq (
    .sys_clk_i   (sys_clk_i),
    .rst_n_i     (rst_n_i),
    .core_cyc_o  (core_cyc_o),
    .core_stb_o  (core_stb_o),
    .core_we_o   (core_we_o),
    .core_addr_o (core_addr_o),
    .core_data_o (core_data_o),
    .core_data_i (core_data_i),
    .core_ack_i  (core_ack_i),
    .exec_i      (exec),
    .op_i        (dec.op),
    .instr_o     (instr),
    .pc_o        (pc),
    .load_data_o (load_data),
    .decode_en_o (decode_en),
    .exec_en_o   (exec_en),
    .wb_en_o     (wb_en)
  );

  core_decode u_core_decode (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .en_i      (decode_en),
    .instr_i   (instr),
    .dec_o     (dec)
  );

  core_execute u_core_execute (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .en_i      (exec_en),
    .dec_i     (dec),
    .pc_i      (pc),
    .rs1_val_i (rs1_val),
    .rs2_val_i (rs2_val),
    .exec_o    (exec)
  );

  core_result u_core_result (
    .sys_clk_i   (sys_clk_i),
    .rst_n_i     (rst_n_i),
    .wb_en_i     (wb_en),
    .dec_i       (dec),
    .exec_i      (exec),
    .load_data_i (load_data),
    .rs1_val_o   (rs1_val),
    .rs2_val_o   (rs2_val)
  );

endmodule

`default_nettype wire

// File: tests/processorci_assert.sv
`timescale 1ns/1ps
`default_nettype none

module processorci_assert (
  input logic                   sys_clk_i,
  input logic                   rst_n_i,
  input logic                   cyc_i,
  input logic                   stb_i,
  input logic                   we_i,
  input processorci_pkg::addr_t addr_i,
  input processorci_pkg::word_t data_i,
  input logic                   ack_i
);

  // Number of failed bus checks
  int fail_cnt = 0;

  // Bus goes idle for at least one cycle after each ack
  idle_after_ack: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    cyc_i && ack_i |=> !cyc_i && !stb_i)
    else begin
      fail_cnt++;
      $error("cyc or stb still high in the cycle after ack");
    end

  // Request held until the slave acks
  stb_held: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    stb_i && !ack_i |=> stb_i)
    else begin
      fail_cnt++;
      $error("stb dropped before ack");
    end

  addr_stable: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    stb_i && !ack_i |=> $stable(addr_i))
    else begin
      fail_cnt++;
      $error("address changed while waiting for ack");
    end

  we_stable: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    stb_i && !ack_i |=> $stable(we_i))
    else begin
      fail_cnt++;
      $error("we changed while waiting for ack");
    end

  data_stable: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
    stb_i && !ack_i |=> $stable(data_i))
    else begin
      fail_cnt++;
      $error("write data changed while waiting for ack");
    end

endmodule

`default_nettype wire

// File: tests/processorci_tb.sv
`timescale 1ns/1ps
`default_nettype none

module processorci_tb;

  localparam int CLK_PERIOD = 100;
  localparam int DRV_DELAY  = 5;
  localparam int N_INSTR    = 40;
  // Fetch plus one data transfer, each up to 4 cycles, plus the fixed phases
  localparam int MAX_CYCLES = N_INSTR * (4 + 2 * 4) + 100;
  localparam processorci_pkg::addr_t BOOT_ADDR = 32'h0000_0000;

  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // Expected effect of one instruction
  typedef struct packed {
    processorci_pkg::addr_t next_pc;
    logic                   is_load;
    logic                   is_store;
    processorci_pkg::addr_t mem_addr;
    processorci_pkg::word_t store_data;
  } step_t;

  logic                   sys_clk;
  logic                   rst_n;
  logic                   core_cyc;
  logic                   core_stb;
  logic                   core_we;
  processorci_pkg::addr_t core_addr;
  processorci_pkg::word_t core_wdata;
  processorci_pkg::word_t core_rdata;
  logic                   core_ack;

  processorci_pkg::word_t mem [256];
  processorci_pkg::word_t shadow_mem [256];
  processorci_pkg::word_t shadow_regs [32];
  processorci_pkg::addr_t ref_pc;
  step_t                  pending;
  logic                   mem_pending;
  int                     instr_cnt;
  int                     cycle_cnt;
  int                     wait_cnt;
  integer                 seed = 18;

  processorci_top #(
    .BOOT_ADDR   (BOOT_ADDR)
  ) i_processorci_top (
    .sys_clk_i   (sys_clk),
    .rst_n_i     (rst_n),
    .core_cyc_o  (core_cyc),
    .core_stb_o  (core_stb),
    .core_we_o   (core_we),
    .core_addr_o (core_addr),
    .core_data_o (core_wdata),
    .core_data_i (core_rdata),
    .core_ack_i  (core_ack)
  );

  bind core_bus_seq processorci_assert i_processorci_assert (
    .sys_clk_i (sys_clk_i),
    .rst_n_i   (rst_n_i),
    .cyc_i     (core_cyc_o),
    .stb_i     (core_stb_o),
    .we_i      (core_we_o),
    .addr_i    (core_addr_o),
    .data_i    (core_data_o),
    .ack_i     (core_ack_i)
  );

  function automatic processorci_pkg::word_t r_type(input int f7, input int rs2, input int rs1,
                                                    input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_REG};
  endfunction

  function automatic processorci_pkg::word_t i_type(input int imm, input int rs1, input int f3,
                                                    input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic processorci_pkg::word_t s_type(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic processorci_pkg::word_t b_type(input int imm, input int rs2, input int rs1,
                                                    input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic processorci_pkg::word_t u_type(input int imm, input int rd);
    return {imm[19:0], rd[4:0], OPC_LUI};
  endfunction

  function automatic processorci_pkg::word_t j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  // Shadow execution of one instruction straight from the RV32I rules
  function automatic step_t ref_step(input processorci_pkg::addr_t pc,
                                     input processorci_pkg::word_t instr);
    step_t                  s;
    processorci_pkg::word_t a;
    processorci_pkg::word_t b;
    processorci_pkg::word_t imm_i;
    processorci_pkg::word_t imm_s;
    processorci_pkg::word_t val;
    logic                   wr;
    logic [4:0]             rd;
    a     = shadow_regs[instr[19:15]];
    b     = shadow_regs[instr[24:20]];
    rd    = instr[11:7];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    s         = '0;
    s.next_pc = pc + 32'd4;
    wr        = 1'b0;
    val       = '0;
    case (instr[6:0])
      OPC_REG: begin
        wr = 1'b1;
        case ({instr[31:25], instr[14:12]})
          10'b0000000_000: val = a + b;
          10'b0100000_000: val = a - b;
          10'b0000000_111: val = a & b;
          10'b0000000_110: val = a | b;
          10'b0000000_100: val = a ^ b;
          default:         wr = 1'b0;
        endcase
      end
      OPC_IMM: begin
        wr  = (instr[14:12] == 3'b000);
        val = a + imm_i;
      end
      OPC_LUI: begin
        wr  = 1'b1;
        val = {instr[31:12], 12'b0};
      end
      OPC_LOAD: begin
        if (instr[14:12] == 3'b010) begin
          s.is_load  = 1'b1;
          s.mem_addr = a + imm_i;
          wr         = 1'b1;
          val        = shadow_mem[s.mem_addr[9:2]];
        end
      end
      OPC_STORE: begin
        if (instr[14:12] == 3'b010) begin
          s.is_store   = 1'b1;
          s.mem_addr   = a + imm_s;
          s.store_data = b;
          shadow_mem[s.mem_addr[9:2]] = b;
        end
      end
      OPC_BRANCH: begin
        if ((instr[14:12] == 3'b000 && a == b) || (instr[14:12] == 3'b001 && a != b)) begin
          s.next_pc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
        end
      end
      OPC_JAL: begin
        wr        = 1'b1;
        val       = pc + 32'd4;
        s.next_pc = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0) begin
      shadow_regs[rd] = val;
    end
    return s;
  endfunction

  task automatic compare_value(input string name, input processorci_pkg::word_t got,
                               input processorci_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR: time %0t signal %s got %h expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic load_program();
    int imm_a;
    int imm_b;
    int imm_u;
    imm_a = $random(seed) % 2048;
    imm_b = $random(seed) % 2048;
    imm_u = $random(seed);
    // Keeps the x1/x2 branches on both sides
    if (imm_b == imm_a) begin
      imm_b = imm_a ^ 1;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h9E37_79B9 * (i + 1);
    end
    mem[0]  = i_type(32'h200, 0, 0, 10, OPC_IMM);
    mem[1]  = i_type(imm_a, 0, 0, 1, OPC_IMM);
    mem[2]  = i_type(imm_b, 0, 0, 2, OPC_IMM);
    mem[3]  = u_type(imm_u, 3);
    mem[4]  = r_type(0, 2, 1, 0, 4);
    mem[5]  = r_type(32, 2, 1, 0, 5);
    mem[6]  = r_type(0, 3, 1, 7, 6);
    mem[7]  = r_type(0, 3, 2, 6, 7);
    mem[8]  = r_type(0, 5, 4, 4, 8);
    for (int k = 0; k < 5; k++) begin
      mem[9 + k] = s_type(4 * k, 4 + k, 10);
    end
    mem[14] = i_type(64, 10, 2, 9, OPC_LOAD);
    mem[15] = s_type(20, 9, 10);
    mem[16] = i_type(5, 0, 0, 0, OPC_IMM);
    mem[17] = s_type(24, 0, 10);
    mem[18] = b_type(8, 1, 1, 0);
    mem[19] = i_type(1, 11, 0, 11, OPC_IMM);
    mem[20] = b_type(8, 1, 1, 1);
    mem[21] = b_type(8, 2, 1, 0);
    mem[22] = b_type(8, 2, 1, 1);
    mem[23] = i_type(2, 11, 0, 11, OPC_IMM);
    mem[24] = j_type(8, 12);
    mem[25] = i_type(4, 11, 0, 11, OPC_IMM);
    mem[26] = s_type(28, 12, 10);
    mem[27] = s_type(32, 11, 10);
    // Custom-0 opcode, runs as a no-op
    mem[28] = 32'h0000_000B;
    mem[29] = j_type(0, 0);
  endtask

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  // Memory answers each transfer after 0 to 3 wait cycles
  initial begin
    core_ack   = 1'b0;
    core_rdata = '0;
    wait_cnt   = -1;
    forever begin
      @(posedge sys_clk);
      #DRV_DELAY;
      if (core_ack) begin
        core_ack = 1'b0;
      end else if (core_cyc && core_stb) begin
        if (wait_cnt < 0) begin
          wait_cnt = $unsigned($random(seed)) % 4;
        end
        if (wait_cnt == 0) begin
          if (core_we) begin
            mem[core_addr[9:2]] = core_wdata;
          end else begin
            core_rdata = mem[core_addr[9:2]];
          end
          core_ack = 1'b1;
        end
        wait_cnt--;
      end
    end
  end

  // Every acked transfer against the shadow model
  always @(negedge sys_clk) begin
    if (rst_n && core_cyc && core_stb && core_ack) begin
      if (!mem_pending) begin
        compare_value("core_we_o", {31'd0, core_we}, 32'd0);
        compare_value("core_addr_o", core_addr, ref_pc);
        pending     = ref_step(ref_pc, shadow_mem[ref_pc[9:2]]);
        ref_pc      = pending.next_pc;
        mem_pending = pending.is_load || pending.is_store;
        instr_cnt++;
      end else begin
        compare_value("core_we_o", {31'd0, core_we}, {31'd0, pending.is_store});
        compare_value("core_addr_o", core_addr, pending.mem_addr);
        if (pending.is_store) begin
          compare_value("core_data_o", core_wdata, pending.store_data);
        end
        mem_pending = 1'b0;
      end
    end
  end

  // Stop at the first failed bus protocol assertion
  always @(i_processorci_top.u_core_bus_seq.i_processorci_assert.fail_cnt) begin
    if (i_processorci_top.u_core_bus_seq.i_processorci_assert.fail_cnt != 0) begin
      $display("Bus protocol assertion failed at time %0t", $time);
      $display("sim failed");
      $fatal(1, "Bus protocol assertion failed");
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge sys_clk);
      cycle_cnt++;
    end
    $display("Timeout: %0d instructions not completed in %0d cycles", N_INSTR, MAX_CYCLES);
    $display("sim failed");
    $fatal(1, "Timeout");
  end

  initial begin
    rst_n       = 1'b0;
    ref_pc      = BOOT_ADDR;
    mem_pending = 1'b0;
    instr_cnt   = 0;
    pending     = '0;
    load_program();
    for (int i = 0; i < 256; i++) begin
      shadow_mem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++) begin
      shadow_regs[i] = '0;
    end
    // Bus stays idle throughout reset
    repeat (4) begin
      @(posedge sys_clk);
      #DRV_DELAY;
      compare_value("core_cyc_o", {31'd0, core_cyc}, 32'd0);
      compare_value("core_stb_o", {31'd0, core_stb}, 32'd0);
    end
    rst_n = 1'b1;
    wait (instr_cnt == N_INSTR);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/processorci_pkg.sv
hdl/core_bus_seq.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_result.sv
hdl/processorci_top.sv
tests/processorci_assert.sv
tests/processorci_tb.sv
